// ==== common/div_pkg.sv ====
package div_pkg;

	// operand and result width
	localparam int DIV_WIDTH = 32;

	// residual width, two guard bits above the operands
	localparam int DIV_EXT_WIDTH = 34;

	// holds a leading-digit position of a DIV_EXT_WIDTH operand
	localparam int DIV_POS_WIDTH = 6;

	typedef logic [DIV_WIDTH-1:0] div_word_t;

	// bit 0 set means unsigned, bit 1 set means remainder
	typedef enum logic [1:0] {
		OP_DIV  = 2'b00, // signed quotient
		OP_DIVU = 2'b01, // unsigned quotient
		OP_REM  = 2'b10, // signed remainder
		OP_REMU = 2'b11  // unsigned remainder
	} div_op_t;

	// cases that never reach the iterative core
	typedef enum logic [1:0] {
		SPC_NONE = 2'b00,
		SPC_ZERO = 2'b01, // divisor is zero
		SPC_OVFL = 2'b10  // most negative / -1
	} div_special_t;

endpackage

// ==== srt_div/lead_digit_find.sv ====
`timescale 1ns/1ps

module lead_digit_find #(
	parameter int WID = 34
) (
	input  logic [WID-1:0]         op_i,
	output logic [$clog2(WID)-1:0] pos_o
);

	logic [WID-2:0] mag;       // bits below the sign, sign folded away
	logic [WID-2:0] rev;       // mag reversed, msb first at index 0
	logic [WID-2:0] first_one; // onehot of the first differing bit

	assign mag = op_i[WID-2:0] ^ {(WID-1){op_i[WID-1]}};

	always_comb begin
		for (int i = 0; i < WID-1; i++) begin
			rev[i] = mag[WID-2-i];
		end
	end

	// two's complement mask keeps only the lowest set bit
	assign first_one = rev & (~rev + 1'b1);

	always_comb begin
		pos_o = $bits(pos_o)'(WID-1); // all sign bits, zero or minus one
		for (int j = 0; j < WID-1; j++) begin
			if (first_one[j]) begin
				pos_o = $bits(pos_o)'(j);
			end
		end
	end

endmodule

// ==== srt_div/srt_qds.sv ====
`timescale 1ns/1ps

module srt_qds #(
	parameter int WID = 34
) (
	input  logic [WID-1:0] residual_i,
	input  logic           divisor_sign_i,
	output logic           digit_o,
	output logic           negative_o
);

	logic [2:0] top; // bits just below the sign

	assign top = residual_i[WID-2:WID-4];

	// zero digit while the doubled residual sits inside +-1/2 of the divisor scale
	always_comb begin
		if (residual_i[WID-1]) begin
			digit_o = (top < 3'b110);
		end else begin
			digit_o = (top >= 3'b010);
		end
	end

	assign negative_o = digit_o & (residual_i[WID-1] ^ divisor_sign_i);

endmodule

// ==== srt_div/srt_div_core.sv ====
`timescale 1ns/1ps

module srt_div_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_i,
	input  logic               signed_i,
	input  div_pkg::div_word_t dividend_i,
	input  div_pkg::div_word_t divisor_i,
	output logic               ready_o,
	output logic               done_o,
	output div_pkg::div_word_t quotient_o,
	output div_pkg::div_word_t remainder_o
);

	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_SAMP = 2'b01,
		ST_DIV  = 2'b10,
		ST_OUT  = 2'b11
	} core_state_t;

	core_state_t state;

	logic [div_pkg::DIV_EXT_WIDTH-1:0] op_x;     // extended dividend
	logic [div_pkg::DIV_EXT_WIDTH-1:0] op_d;     // extended divisor
	logic [div_pkg::DIV_POS_WIDTH-1:0] pos_x;
	logic [div_pkg::DIV_POS_WIDTH-1:0] pos_d;
	logic [div_pkg::DIV_EXT_WIDTH-1:0] x_norm;   // one redundant sign bit left
	logic [div_pkg::DIV_EXT_WIDTH-1:0] d_norm;   // fully normalized
	logic [div_pkg::DIV_POS_WIDTH:0]   step_diff; // quotient bits, signed
	logic [div_pkg::DIV_POS_WIDTH-1:0] cnt;
	logic                              short_r;  // |dividend| below |divisor|
	logic [div_pkg::DIV_EXT_WIDTH-1:0] rem_r;
	logic [div_pkg::DIV_EXT_WIDTH-1:0] rem_2x;
	logic [div_pkg::DIV_EXT_WIDTH-1:0] rem_next;
	logic [div_pkg::DIV_EXT_WIDTH-1:0] q_r;
	logic [div_pkg::DIV_EXT_WIDTH-1:0] qm_r;     // always q_r - 1
	logic [div_pkg::DIV_EXT_WIDTH-1:0] quo_fix;
	logic [div_pkg::DIV_EXT_WIDTH-1:0] rem_fix;
	logic [div_pkg::DIV_EXT_WIDTH-1:0] rem_shift;
	logic                              digit;
	logic                              neg;

	lead_digit_find #(
		.WID (div_pkg::DIV_EXT_WIDTH)
	) u_ld_dividend (
		.op_i  (op_x),
		.pos_o (pos_x)
	);

	lead_digit_find #(
		.WID (div_pkg::DIV_EXT_WIDTH)
	) u_ld_divisor (
		.op_i  (op_d),
		.pos_o (pos_d)
	);

	assign x_norm = op_x << (pos_x - 1'b1);
	assign d_norm = op_d << pos_d;
	assign step_diff = {1'b0, pos_d} + 1'b1 - {1'b0, pos_x};

	srt_qds #(
		.WID (div_pkg::DIV_EXT_WIDTH)
	) u_qds (
		.residual_i     (rem_r),
		.divisor_sign_i (d_norm[div_pkg::DIV_EXT_WIDTH-1]),
		.digit_o        (digit),
		.negative_o     (neg)
	);

	// wraps in the top bit, the true next residual still fits
	assign rem_2x = {rem_r[div_pkg::DIV_EXT_WIDTH-2:0], 1'b0};

	always_comb begin
		if (!digit) begin
			rem_next = rem_2x;
		end else if (neg) begin
			rem_next = rem_2x + d_norm;
		end else begin
			rem_next = rem_2x - d_norm;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: if (start_i) state <= ST_SAMP;
				ST_SAMP: begin
					state <= ST_DIV;
					cnt   <= step_diff[div_pkg::DIV_POS_WIDTH] ? '0 :
						step_diff[div_pkg::DIV_POS_WIDTH-1:0];
				end
				ST_DIV: begin
					if (cnt == '0) begin
						state <= ST_OUT;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= ST_IDLE; // ST_OUT
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start_i) begin
			op_x <= {{(div_pkg::DIV_EXT_WIDTH-div_pkg::DIV_WIDTH)
				{signed_i & dividend_i[div_pkg::DIV_WIDTH-1]}}, dividend_i};
			op_d <= {{(div_pkg::DIV_EXT_WIDTH-div_pkg::DIV_WIDTH)
				{signed_i & divisor_i[div_pkg::DIV_WIDTH-1]}}, divisor_i};
		end
		if (state == ST_SAMP) begin
			rem_r   <= x_norm;
			q_r     <= '0;
			qm_r    <= '1;
			short_r <= step_diff[div_pkg::DIV_POS_WIDTH];
		end else if (state == ST_DIV && cnt != '0) begin
			rem_r <= rem_next;
			// on-the-fly conversion, no carry chain per step
			q_r   <= neg ? {qm_r[div_pkg::DIV_EXT_WIDTH-2:0], 1'b1} :
				{q_r[div_pkg::DIV_EXT_WIDTH-2:0], digit};
			qm_r  <= (digit & ~neg) ? {q_r[div_pkg::DIV_EXT_WIDTH-2:0], 1'b0} :
				{qm_r[div_pkg::DIV_EXT_WIDTH-2:0], ~digit};
		end
	end

	// residual must end with the dividend's sign and below |divisor|
	always_comb begin
		quo_fix = q_r;
		rem_fix = rem_r;
		if (rem_r == d_norm) begin
			quo_fix = q_r + 1'b1;
			rem_fix = '0;
		end else if (rem_r == -d_norm) begin
			quo_fix = q_r - 1'b1;
			rem_fix = '0;
		end else if (rem_r != '0 &&
			rem_r[div_pkg::DIV_EXT_WIDTH-1] != op_x[div_pkg::DIV_EXT_WIDTH-1]) begin
			if (rem_r[div_pkg::DIV_EXT_WIDTH-1] == d_norm[div_pkg::DIV_EXT_WIDTH-1]) begin
				quo_fix = q_r + 1'b1;
				rem_fix = rem_r - d_norm;
			end else begin
				quo_fix = q_r - 1'b1;
				rem_fix = rem_r + d_norm;
			end
		end
	end

	assign rem_shift = $signed(rem_fix) >>> pos_d; // undo divisor normalization

	always_ff @(posedge clk) begin
		if (state == ST_OUT) begin
			quotient_o  <= short_r ? '0 : quo_fix[div_pkg::DIV_WIDTH-1:0];
			remainder_o <= short_r ? op_x[div_pkg::DIV_WIDTH-1:0] :
				rem_shift[div_pkg::DIV_WIDTH-1:0];
		end
	end

	assign ready_o = (state == ST_IDLE);
	assign done_o  = (state == ST_OUT);

endmodule

// ==== rtl/div_decode.sv ====
`timescale 1ns/1ps

module div_decode (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_i,
	input  div_pkg::div_op_t      op_i,
	input  div_pkg::div_word_t    dividend_i,
	input  div_pkg::div_word_t    divisor_i,
	input  logic                  core_ready_i,
	input  logic                  busy_i,
	output logic                  start_o,
	output logic                  launch_o,
	output logic                  signed_o,
	output logic                  want_rem_o,
	output div_pkg::div_special_t special_o,
	output div_pkg::div_word_t    dividend_o,
	output div_pkg::div_word_t    divisor_o
);

	logic                  armed;  // req_i has been low since the last accept
	logic                  accept;
	logic                  is_signed;
	div_pkg::div_special_t special_d;

	assign accept    = req_i & armed & ~busy_i & core_ready_i;
	assign is_signed = (op_i == div_pkg::OP_DIV) || (op_i == div_pkg::OP_REM);

	always_comb begin
		if (divisor_i == '0) begin
			special_d = div_pkg::SPC_ZERO;
		end else if (is_signed && divisor_i == '1 &&
			dividend_i == {1'b1, {(div_pkg::DIV_WIDTH-1){1'b0}}}) begin
			special_d = div_pkg::SPC_OVFL;
		end else begin
			special_d = div_pkg::SPC_NONE;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			armed    <= 1'b1;
			launch_o <= 1'b0;
			start_o  <= 1'b0;
		end else begin
			if (accept) armed <= 1'b0;
			else if (!req_i) armed <= 1'b1;
			launch_o <= accept;
			start_o  <= accept && special_d == div_pkg::SPC_NONE; // core only sees real work
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			signed_o   <= is_signed;
			want_rem_o <= (op_i == div_pkg::OP_REM) || (op_i == div_pkg::OP_REMU);
			special_o  <= special_d;
			dividend_o <= dividend_i;
			divisor_o  <= divisor_i;
		end
	end

endmodule

// ==== rtl/div_result.sv ====
`timescale 1ns/1ps

module div_result (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_i,
	input  logic                  launch_i,
	input  div_pkg::div_special_t special_i,
	input  logic                  want_rem_i,
	input  logic                  signed_i,
	input  div_pkg::div_word_t    dividend_i,
	input  logic                  core_done_i,
	input  div_pkg::div_word_t    quotient_i,
	input  div_pkg::div_word_t    remainder_i,
	output logic                  busy_o,
	output logic                  ack_o,
	output div_pkg::div_word_t    result_o
);

	typedef enum logic [1:0] {
		ST_WAIT  = 2'b00, // idle or core running
		ST_LOAD  = 2'b01, // core outputs settle after done
		ST_ACKED = 2'b10
	} res_state_t;

	res_state_t         state;
	div_pkg::div_word_t spc_result;

	always_comb begin
		if (special_i == div_pkg::SPC_ZERO) begin
			spc_result = want_rem_i ? dividend_i : '1;
		end else begin
			// overflow, quotient is the most negative value
			spc_result = want_rem_i ? '0 : {signed_i, {(div_pkg::DIV_WIDTH-1){1'b0}}};
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state  <= ST_WAIT;
			busy_o <= 1'b0;
			ack_o  <= 1'b0;
		end else begin
			case (state)
				ST_WAIT: begin
					if (launch_i) busy_o <= 1'b1;
					if (launch_i && special_i != div_pkg::SPC_NONE) begin
						ack_o <= 1'b1;
						state <= ST_ACKED;
					end else if (core_done_i) begin
						state <= ST_LOAD;
					end
				end
				ST_LOAD: begin
					ack_o <= 1'b1;
					state <= ST_ACKED;
				end
				default: begin
					if (!req_i) begin // four-phase release
						ack_o  <= 1'b0;
						busy_o <= 1'b0;
						state  <= ST_WAIT;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_WAIT && launch_i && special_i != div_pkg::SPC_NONE) begin
			result_o <= spc_result;
		end else if (state == ST_LOAD) begin
			result_o <= want_rem_i ? remainder_i : quotient_i;
		end
	end

endmodule

// ==== rtl/div_unit_top.sv ====
`timescale 1ns/1ps

module div_unit_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_i,
	input  div_pkg::div_op_t   op_i,
	input  div_pkg::div_word_t dividend_i,
	input  div_pkg::div_word_t divisor_i,
	output logic               ack_o,
	output div_pkg::div_word_t result_o
);

	logic                  start;
	logic                  launch;
	logic                  signed_mode;
	logic                  want_rem;
	div_pkg::div_special_t special;
	div_pkg::div_word_t    dividend_q; // registered request operands
	div_pkg::div_word_t    divisor_q;
	logic                  core_ready;
	logic                  core_done;
	div_pkg::div_word_t    quotient;
	div_pkg::div_word_t    remainder;
	logic                  busy;

	div_decode u_decode (
		.clk          (clk),
		.rst          (rst),
		.req_i        (req_i),
		.op_i         (op_i),
		.dividend_i   (dividend_i),
		.divisor_i    (divisor_i),
		.core_ready_i (core_ready),
		.busy_i       (busy),
		.start_o      (start),
		.launch_o     (launch),
		.signed_o     (signed_mode),
		.want_rem_o   (want_rem),
		.special_o    (special),
		.dividend_o   (dividend_q),
		.divisor_o    (divisor_q)
	);

	srt_div_core u_core (
		.clk         (clk),
		.rst         (rst),
		.start_i     (start),
		.signed_i    (signed_mode),
		.dividend_i  (dividend_q),
		.divisor_i   (divisor_q),
		.ready_o     (core_ready),
		.done_o      (core_done),
		.quotient_o  (quotient),
		.remainder_o (remainder)
	);

	div_result u_result (
		.clk         (clk),
		.rst         (rst),
		.req_i       (req_i),
		.launch_i    (launch),
		.special_i   (special),
		.want_rem_i  (want_rem),
		.signed_i    (signed_mode),
		.dividend_i  (dividend_q),
		.core_done_i (core_done),
		.quotient_i  (quotient),
		.remainder_i (remainder),
		.busy_o      (busy),
		.ack_o       (ack_o),
		.result_o    (result_o)
	);

endmodule

// ==== tests/div_tb_clk.sv ====
`timescale 1ns/1ps

module div_tb_clk #(
	parameter int HALF_PERIOD = 5,
	parameter int RST_CYCLES  = 3
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// active low, released just after an edge
	initial begin
		rst_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		#1 rst_o = 1'b1;
	end

endmodule

// ==== tests/div_tb.sv ====
`timescale 1ns/1ps

module div_tb;

	localparam int MAX_CYCLES = 300 * 60;

	logic               clk;
	logic               rst;
	logic               req_i;
	div_pkg::div_op_t   op_i;
	div_pkg::div_word_t dividend_i;
	div_pkg::div_word_t divisor_i;
	logic               ack_o;
	div_pkg::div_word_t result_o;

	int                 value_errors = 0;
	int                 hs_errors = 0;
	int                 other_errors = 0;
	int                 cycles = 0;
	int unsigned        seed;
	logic               pending = 1'b0; // a result is awaited
	div_pkg::div_word_t exp_val;
	string              exp_name;
	logic               prev_ack = 1'b0;
	div_pkg::div_word_t prev_result;

	div_tb_clk u_clk (
		.clk_o (clk),
		.rst_o (rst)
	);

	div_unit_top DUT (
		.clk        (clk),
		.rst        (rst),
		.req_i      (req_i),
		.op_i       (op_i),
		.dividend_i (dividend_i),
		.divisor_i  (divisor_i),
		.ack_o      (ack_o),
		.result_o   (result_o)
	);

	// RISC-V M-extension divide semantics
	function automatic div_pkg::div_word_t ref_div(input div_pkg::div_op_t op,
		input div_pkg::div_word_t a, input div_pkg::div_word_t b);
		logic               sgn;
		logic               rem;
		div_pkg::div_word_t mag_a;
		div_pkg::div_word_t mag_b;
		div_pkg::div_word_t q;
		div_pkg::div_word_t r;
		sgn = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
		rem = (op == div_pkg::OP_REM) || (op == div_pkg::OP_REMU);
		if (b == '0) return rem ? a : '1;
		if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) return rem ? '0 : a;
		mag_a = (sgn && a[div_pkg::DIV_WIDTH-1]) ? -a : a;
		mag_b = (sgn && b[div_pkg::DIV_WIDTH-1]) ? -b : b;
		q = mag_a / mag_b;
		r = mag_a % mag_b;
		if (sgn && (a[div_pkg::DIV_WIDTH-1] ^ b[div_pkg::DIV_WIDTH-1])) q = -q;
		if (sgn && a[div_pkg::DIV_WIDTH-1]) r = -r; // remainder follows dividend
		return rem ? r : q;
	endfunction

	function automatic string op_label(input div_pkg::div_op_t op);
		case (op)
			div_pkg::OP_DIV:  return "div";
			div_pkg::OP_DIVU: return "divu";
			div_pkg::OP_REM:  return "rem";
			default:          return "remu";
		endcase
	endfunction

	task automatic check_result(input string name, input div_pkg::div_word_t exp_v,
		input div_pkg::div_word_t act_v);
		if (act_v !== exp_v) begin
			value_errors++;
			$display("** Error: %s expected %h actual %h", name, exp_v, act_v);
		end
	endtask

	// one full four-phase transaction
	task automatic do_request(input string name, input div_pkg::div_op_t op,
		input div_pkg::div_word_t a, input div_pkg::div_word_t b, input int extra_hold);
		int hold;
		hold = extra_hold + $urandom_range(0, 5);
		exp_val  = ref_div(op, a, b);
		exp_name = $sformatf("%s %s %h/%h", name, op_label(op), a, b);
		@(posedge clk);
		#1;
		op_i       = op;
		dividend_i = a;
		divisor_i  = b;
		req_i      = 1'b1;
		pending    = 1'b1;
		wait (!pending);
		repeat (hold) begin
			@(negedge clk);
			if (ack_o !== 1'b1) begin
				other_errors++;
				$display("%s: ack_o dropped while req_i was still held", exp_name);
			end
		end
		@(posedge clk);
		#1;
		req_i = 1'b0;
		@(negedge clk);
		while (ack_o) @(negedge clk);
	endtask

	task automatic request_all_ops(input string name, input div_pkg::div_word_t a,
		input div_pkg::div_word_t b);
		do_request(name, div_pkg::OP_DIV, a, b, 0);
		do_request(name, div_pkg::OP_DIVU, a, b, 0);
		do_request(name, div_pkg::OP_REM, a, b, 0);
		do_request(name, div_pkg::OP_REMU, a, b, 0);
	endtask

	// one compare per ack at mid-cycle
	always @(negedge clk) begin
		if (pending && ack_o) begin
			check_result(exp_name, exp_val, result_o);
			pending = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (rst) begin
			if (ack_o && !prev_ack && !req_i) begin
				hs_errors++;
				$display("handshake: ack_o rose while req_i was low");
			end
			if (!ack_o && prev_ack && req_i) begin
				hs_errors++;
				$display("handshake: ack_o fell while req_i was still high");
			end
			if (ack_o && prev_ack && result_o !== prev_result) begin
				hs_errors++;
				$display("handshake: result_o changed while ack_o was high");
			end
		end
		prev_ack    = ack_o;
		prev_result = result_o;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		div_pkg::div_op_t   op;
		div_pkg::div_word_t a;
		div_pkg::div_word_t b;
		int                 sel;
		seed       = $urandom(32'h5055);
		req_i      = 1'b0;
		op_i       = div_pkg::OP_DIV;
		dividend_i = '0;
		divisor_i  = '0;
		wait (rst === 1'b1);
		repeat (4) begin
			@(negedge clk);
			if (ack_o !== 1'b0) begin
				other_errors++;
				$display("ack_o is not low after reset with no request pending");
			end
		end

		// unsigned corners
		request_all_ops("small", 32'd100, 32'd7);
		request_all_ops("below", 32'd7, 32'd100);
		request_all_ops("by one", 32'd12345, 32'd1);
		request_all_ops("ones", 32'hffff_ffff, 32'hffff_ffff);
		request_all_ops("ones by two", 32'hffff_ffff, 32'd2);
		request_all_ops("zero dividend", 32'd0, 32'd5);
		request_all_ops("mixed", 32'hdead_beef, 32'h0000_1234);
		// sign combinations
		request_all_ops("neg pos", -32'd100, 32'd7);
		request_all_ops("pos neg", 32'd100, -32'd7);
		request_all_ops("neg neg", -32'd100, -32'd7);
		request_all_ops("exact pos neg", 32'd42, -32'd6);
		request_all_ops("exact neg pos", -32'd42, 32'd6);
		request_all_ops("exact neg neg", -32'd42, -32'd6);
		request_all_ops("min by 3", 32'h8000_0000, 32'd3);
		request_all_ops("min by -3", 32'h8000_0000, -32'd3);
		request_all_ops("min by 2", 32'h8000_0000, 32'd2);
		request_all_ops("min by min", 32'h8000_0000, 32'h8000_0000);
		// special cases
		request_all_ops("zero div", 32'd123, 32'd0);
		request_all_ops("min zero div", 32'h8000_0000, 32'd0);
		request_all_ops("overflow", 32'h8000_0000, 32'hffff_ffff);
		// long hold on the request
		do_request("hold", div_pkg::OP_DIV, -32'd1000, 32'd7, 20);
		do_request("hold", div_pkg::OP_REMU, 32'd5, 32'd0, 20);

		for (int i = 0; i < 200; i++) begin
			op  = div_pkg::div_op_t'($urandom_range(0, 3));
			a   = $urandom;
			b   = $urandom;
			sel = $urandom_range(0, 15);
			if (sel == 0) begin
				b = '0;
			end else if (sel == 1) begin
				b = '1;
				if ($urandom_range(0, 1) == 1) a = 32'h8000_0000;
			end else if (sel < 5) begin
				b = $urandom_range(1, 255);
			end else if (sel < 8) begin
				a = a >> $urandom_range(0, 31); // vary quotient length
			end
			do_request($sformatf("rand %0d", i), op, a, b, 0);
		end

		repeat (2) @(posedge clk);
		$display("errors: %0d value, %0d handshake, %0d other",
			value_errors, hs_errors, other_errors);
		if (value_errors + hs_errors + other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
common/div_pkg.sv
srt_div/lead_digit_find.sv
srt_div/srt_qds.sv
srt_div/srt_div_core.sv
rtl/div_decode.sv
rtl/div_result.sv
rtl/div_unit_top.sv
tests/div_tb_clk.sv
tests/div_tb.sv
